//--- include/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// datapath and register index widths
`define PIPE_XLEN 32
`define PIPE_REGW 5
// stall/flush vector width, one bit per pipeline register plus pc
`define PIPE_NSTG 6
// iterations per mul/div
`define MDU_STEPS 32

// stage bits, pc on top
`define STG_PC     5
`define STG_IF_ID  4
`define STG_ID_EX  3
`define STG_EX_MEM 2
`define STG_MEM_WB 1
`define STG_WB     0

// stall/flush pair per hazard cause
`define RAM_MEM_STALL    6'b001111
`define RAM_MEM_FLUSH    6'b010000
`define RAM_IF_STALL     6'b110000
`define RAM_IF_FLUSH     6'b000000
`define TRAP_FLUSH_STALL 6'b000010
`define TRAP_FLUSH_FLUSH 6'b001110
`define TRAP_STALL_STALL 6'b111111
`define TRAP_STALL_FLUSH 6'b001110
`define JUMP_STALL       6'b000010
`define JUMP_FLUSH       6'b000110
`define MULDIV_STALL     6'b000111
`define MULDIV_FLUSH     6'b001000
`define LOAD_USE_STALL   6'b000011
`define LOAD_USE_FLUSH   6'b000100
`define RESET_STALL      6'b000000
`define RESET_FLUSH      6'b011111

`endif

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // winning hazard, lowest priority first
  typedef enum logic [3:0] {
    NONE,
    LOAD_USE,
    MULDIV,
    JUMP,
    TRAP_STALL,
    TRAP_FLUSH,
    RAM_IF,
    RAM_MEM,
    RESET
  } hazard_cause_e;

  typedef enum logic [1:0] {MDU_MUL, MDU_DIVU, MDU_REMU} mdu_op_e;  // funct3 subset

  typedef enum logic [1:0] {IDLE, RUN, DONE} mdu_state_e;

  typedef enum logic [1:0] {ARB_IDLE, ARB_IF, ARB_MEM} arb_state_e;  // who owns the bus

endpackage

`default_nettype wire

//--- rtl/load_use_detect.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module load_use_detect (
  input  logic [`PIPE_REGW-1:0] id_rs1_i,       // sources of the instr in ID
  input  logic [`PIPE_REGW-1:0] id_rs2_i,
  input  logic [`PIPE_REGW-1:0] ex_rd_i,        // dest of the instr in EX
  input  logic                  ex_mem_read_i,  // EX holds a load
  output logic                  load_use_o
);

  logic rd_live;  // load really writes something
  logic rs1_hit;
  logic rs2_hit;

  // x0 is hardwired to zero, never a real dependency
  assign rd_live = ex_mem_read_i && (ex_rd_i != '0);

  // rs2 compared even for I-type, costs at most one extra bubble
  assign rs1_hit = (id_rs1_i == ex_rd_i);
  assign rs2_hit = (id_rs2_i == ex_rd_i);

  // data only exists after MEM, so ID must wait one cycle
  assign load_use_o = rd_live && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

//--- rtl/pipeline_control.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module pipeline_control (
  input  logic                    clk,                     // assertion sampling
  input  logic                    rst,
  input  logic                    ram_stall_valid_mem_i,   // data port waiting on bus
  input  logic                    ram_stall_valid_if_i,    // fetch waiting on bus
  input  logic                    trap_flush_valid_wb_i,   // ecall/irq taken in WB
  input  logic                    trap_stall_valid_wb_i,   // csr side effect pending
  input  logic                    jump_valid_ex_i,         // branch resolved taken in EX
  input  logic                    alu_mul_div_valid_ex_i,  // mdu still iterating
  input  logic                    load_use_valid_id_i,
  output logic [`PIPE_NSTG-1:0]   stall_o,                 // pc .. mem_wb hold
  output logic [`PIPE_NSTG-1:0]   flush_o,                 // pc .. mem_wb bubble
  output pipe_pkg::hazard_cause_e cause_o                  // debug only
);

  // stage bits from ex_mem back to pc
  localparam logic [`PIPE_NSTG-1:0] UPPER_MASK = {`PIPE_NSTG{1'b1}} << `STG_EX_MEM;

  // later stage wins, reset above all
  always_comb begin
    if (rst)
      cause_o = pipe_pkg::RESET;
    else if (ram_stall_valid_mem_i)
      cause_o = pipe_pkg::RAM_MEM;     // whole front end waits for the load/store
    else if (ram_stall_valid_if_i)
      cause_o = pipe_pkg::RAM_IF;
    else if (trap_flush_valid_wb_i)
      cause_o = pipe_pkg::TRAP_FLUSH;
    else if (trap_stall_valid_wb_i)
      cause_o = pipe_pkg::TRAP_STALL;
    else if (jump_valid_ex_i)
      cause_o = pipe_pkg::JUMP;        // kill the two wrong-path instrs
    else if (alu_mul_div_valid_ex_i)
      cause_o = pipe_pkg::MULDIV;
    else if (load_use_valid_id_i)
      cause_o = pipe_pkg::LOAD_USE;
    else
      cause_o = pipe_pkg::NONE;
  end

  // cause to code pair
  always_comb begin
    unique case (cause_o)
      pipe_pkg::RESET:      {stall_o, flush_o} = {`RESET_STALL, `RESET_FLUSH};
      pipe_pkg::RAM_MEM:    {stall_o, flush_o} = {`RAM_MEM_STALL, `RAM_MEM_FLUSH};
      pipe_pkg::RAM_IF:     {stall_o, flush_o} = {`RAM_IF_STALL, `RAM_IF_FLUSH};
      pipe_pkg::TRAP_FLUSH: {stall_o, flush_o} = {`TRAP_FLUSH_STALL, `TRAP_FLUSH_FLUSH};
      pipe_pkg::TRAP_STALL: {stall_o, flush_o} = {`TRAP_STALL_STALL, `TRAP_STALL_FLUSH};
      pipe_pkg::JUMP:       {stall_o, flush_o} = {`JUMP_STALL, `JUMP_FLUSH};
      pipe_pkg::MULDIV:     {stall_o, flush_o} = {`MULDIV_STALL, `MULDIV_FLUSH};
      pipe_pkg::LOAD_USE:   {stall_o, flush_o} = {`LOAD_USE_STALL, `LOAD_USE_FLUSH};
      default:              {stall_o, flush_o} = '0;  // free running
    endcase
  end

  // reset must win over any request arriving in the same cycle
  a_rst_no_stall: assert property (@(posedge clk) rst |-> (stall_o == `RESET_STALL));
  a_rst_flush: assert property (@(posedge clk) rst |-> (flush_o == `RESET_FLUSH));

  // a stage is either held or bubbled, trap stall freezes everything on purpose
  a_no_hold_and_kill: assert property (
    @(posedge clk) (cause_o != pipe_pkg::TRAP_STALL) |->
      ((stall_o & flush_o & UPPER_MASK) == '0)
  );

endmodule

`default_nettype wire

//--- rtl/mdu_seq.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module mdu_seq (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start_i,   // one cycle pulse from EX
  input  pipe_pkg::mdu_op_e     op_i,
  input  logic [`PIPE_XLEN-1:0] a_i,       // multiplicand / dividend
  input  logic [`PIPE_XLEN-1:0] b_i,       // multiplier / divisor
  output logic                  busy_o,    // holds EX
  output logic                  done_o,
  output logic [`PIPE_XLEN-1:0] result_o
);

  localparam int CNT_W = $clog2(`MDU_STEPS);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MDU_STEPS - 1);

  pipe_pkg::mdu_state_e  state_q;
  pipe_pkg::mdu_op_e     op_q;
  logic [CNT_W-1:0]      cnt_q;
  logic [`PIPE_XLEN-1:0] acc_q;    // product, or partial remainder
  logic [`PIPE_XLEN-1:0] opa_q;    // shifted multiplicand, or dividend/quotient
  logic [`PIPE_XLEN-1:0] opb_q;    // shifted multiplier, or divisor
  logic [`PIPE_XLEN:0]   shifted;  // remainder with next dividend bit pulled in
  logic                  fits;     // trial subtraction does not go negative
  logic                  load;

  assign load    = start_i && (state_q != pipe_pkg::RUN);
  assign shifted = {acc_q, opa_q[`PIPE_XLEN-1]};
  assign fits    = (shifted >= {1'b0, opb_q});

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= pipe_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        pipe_pkg::RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LAST_STEP)
            state_q <= pipe_pkg::DONE;   // result readable next cycle
        end
        default: begin                   // IDLE, DONE
          cnt_q <= '0;
          if (start_i)
            state_q <= pipe_pkg::RUN;
          else
            state_q <= pipe_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      op_q  <= op_i;
      acc_q <= '0;
      opa_q <= a_i;
      opb_q <= b_i;
    end else if (state_q == pipe_pkg::RUN) begin
      if (op_q == pipe_pkg::MDU_MUL) begin
        if (opb_q[0])
          acc_q <= acc_q + opa_q;        // add shifted multiplicand
        opa_q <= opa_q << 1;
        opb_q <= opb_q >> 1;
      end else begin
        // restoring step, divisor 0 always fits -> q all ones, r = a
        if (fits)
          acc_q <= shifted[`PIPE_XLEN-1:0] - opb_q;
        else
          acc_q <= shifted[`PIPE_XLEN-1:0];
        opa_q <= {opa_q[`PIPE_XLEN-2:0], fits};  // quotient bits enter from the right
      end
    end
  end

  assign busy_o   = start_i || (state_q == pipe_pkg::RUN);  // drops in DONE
  assign done_o   = (state_q == pipe_pkg::DONE);
  assign result_o = (op_q == pipe_pkg::MDU_DIVU) ? opa_q : acc_q;  // mul and remu share acc

  // EX is stalled while running, a second start means the stall leaked
  a_no_start_in_run: assert property (
    @(posedge clk) disable iff (rst) (state_q == pipe_pkg::RUN) |-> !start_i
  );

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module mem_arbiter (
  input  logic                    clk,
  input  logic                    rst,
  // fetch port, read only
  input  logic                    if_req_i,
  input  logic [`PIPE_XLEN-1:0]   if_addr_i,
  output logic [`PIPE_XLEN-1:0]   if_rdata_o,
  output logic                    if_valid_o,
  // data port
  input  logic                    mem_req_i,
  input  logic                    mem_we_i,
  input  logic [`PIPE_XLEN-1:0]   mem_addr_i,
  input  logic [`PIPE_XLEN-1:0]   mem_wdata_i,
  input  logic [`PIPE_XLEN/8-1:0] mem_sel_i,
  output logic [`PIPE_XLEN-1:0]   mem_rdata_o,
  output logic                    mem_valid_o,
  // to pipeline_control
  output logic                    ram_stall_if_o,
  output logic                    ram_stall_mem_o,
  // wishbone classic master
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output logic [`PIPE_XLEN-1:0]   wb_adr_o,
  output logic [`PIPE_XLEN-1:0]   wb_dat_o,
  output logic [`PIPE_XLEN/8-1:0] wb_sel_o,
  input  logic [`PIPE_XLEN-1:0]   wb_dat_i,
  input  logic                    wb_ack_i
);

  pipe_pkg::arb_state_e    state_q;
  logic [`PIPE_XLEN-1:0]   adr_q;
  logic [`PIPE_XLEN-1:0]   dat_q;
  logic [`PIPE_XLEN/8-1:0] sel_q;
  logic                    we_q;
  logic                    if_pend;
  logic                    mem_pend;

  // request still up during its valid cycle, that one is already served
  assign if_pend  = if_req_i && !if_valid_o;
  assign mem_pend = mem_req_i && !mem_valid_o;

  assign ram_stall_if_o  = if_pend;
  assign ram_stall_mem_o = mem_pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= pipe_pkg::ARB_IDLE;
      if_valid_o  <= 1'b0;
      mem_valid_o <= 1'b0;
    end else begin
      if_valid_o  <= 1'b0;  // single cycle pulses
      mem_valid_o <= 1'b0;
      unique case (state_q)
        pipe_pkg::ARB_IDLE: begin
          if (mem_pend)
            state_q <= pipe_pkg::ARB_MEM;  // data port first, it blocks more stages
          else if (if_pend)
            state_q <= pipe_pkg::ARB_IF;
        end
        pipe_pkg::ARB_MEM: begin
          if (wb_ack_i) begin
            state_q     <= pipe_pkg::ARB_IDLE;
            mem_valid_o <= 1'b1;
          end
        end
        default: begin                     // ARB_IF
          if (wb_ack_i) begin
            state_q    <= pipe_pkg::ARB_IDLE;
            if_valid_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // bus fields captured on the way out of idle, frozen during the cycle
  always_ff @(posedge clk) begin
    if (state_q == pipe_pkg::ARB_IDLE) begin
      dat_q <= mem_wdata_i;
      if (mem_pend) begin
        adr_q <= mem_addr_i;
        we_q  <= mem_we_i;
        sel_q <= mem_sel_i;
      end else begin
        adr_q <= if_addr_i;
        we_q  <= 1'b0;   // fetch is always a full word read
        sel_q <= '1;
      end
    end
    if (wb_ack_i && (state_q == pipe_pkg::ARB_MEM))
      mem_rdata_o <= wb_dat_i;
    if (wb_ack_i && (state_q == pipe_pkg::ARB_IF))
      if_rdata_o <= wb_dat_i;
  end

  assign wb_cyc_o = (state_q != pipe_pkg::ARB_IDLE);
  assign wb_stb_o = wb_cyc_o;  // no wait states of our own
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = sel_q;

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o);

  // classic handshake, slave may rely on the address until it acks
  a_adr_stable: assert property (
    @(posedge clk) disable iff (rst) (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o)
  );

endmodule

`default_nettype wire

//--- rtl/pipe_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module pipe_ctrl_top (
  input  logic                    clk,
  input  logic                    rst,
  // ID/EX hazard inputs
  input  logic [`PIPE_REGW-1:0]   id_rs1_i,
  input  logic [`PIPE_REGW-1:0]   id_rs2_i,
  input  logic [`PIPE_REGW-1:0]   ex_rd_i,
  input  logic                    ex_mem_read_i,
  input  logic                    ex_jump_i,
  input  logic                    trap_flush_i,
  input  logic                    trap_stall_i,
  // mul/div
  input  logic                    mdu_start_i,
  input  pipe_pkg::mdu_op_e       mdu_op_i,
  input  logic [`PIPE_XLEN-1:0]   mdu_a_i,
  input  logic [`PIPE_XLEN-1:0]   mdu_b_i,
  output logic                    mdu_done_o,
  output logic [`PIPE_XLEN-1:0]   mdu_result_o,
  // fetch and data ports
  input  logic                    if_req_i,
  input  logic [`PIPE_XLEN-1:0]   if_addr_i,
  output logic [`PIPE_XLEN-1:0]   if_rdata_o,
  output logic                    if_valid_o,
  input  logic                    mem_req_i,
  input  logic                    mem_we_i,
  input  logic [`PIPE_XLEN-1:0]   mem_addr_i,
  input  logic [`PIPE_XLEN-1:0]   mem_wdata_i,
  input  logic [`PIPE_XLEN/8-1:0] mem_sel_i,
  output logic [`PIPE_XLEN-1:0]   mem_rdata_o,
  output logic                    mem_valid_o,
  // wishbone
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output logic [`PIPE_XLEN-1:0]   wb_adr_o,
  output logic [`PIPE_XLEN-1:0]   wb_dat_o,
  output logic [`PIPE_XLEN/8-1:0] wb_sel_o,
  input  logic [`PIPE_XLEN-1:0]   wb_dat_i,
  input  logic                    wb_ack_i,
  // to the pipeline registers
  output logic [`PIPE_NSTG-1:0]   stall_o,
  output logic [`PIPE_NSTG-1:0]   flush_o,
  output pipe_pkg::hazard_cause_e cause_o
);

  logic load_use;
  logic mdu_busy;
  logic ram_stall_if;
  logic ram_stall_mem;

  load_use_detect u_load_use (
    .id_rs1_i(id_rs1_i), .id_rs2_i(id_rs2_i), .ex_rd_i(ex_rd_i),
    .ex_mem_read_i(ex_mem_read_i), .load_use_o(load_use)
  );

  mdu_seq u_mdu (
    .clk(clk), .rst(rst), .start_i(mdu_start_i), .op_i(mdu_op_i),
    .a_i(mdu_a_i), .b_i(mdu_b_i),
    .busy_o(mdu_busy), .done_o(mdu_done_o), .result_o(mdu_result_o)
  );

  mem_arbiter u_arb (
    .clk(clk), .rst(rst),
    .if_req_i(if_req_i), .if_addr_i(if_addr_i),
    .if_rdata_o(if_rdata_o), .if_valid_o(if_valid_o),
    .mem_req_i(mem_req_i), .mem_we_i(mem_we_i), .mem_addr_i(mem_addr_i),
    .mem_wdata_i(mem_wdata_i), .mem_sel_i(mem_sel_i),
    .mem_rdata_o(mem_rdata_o), .mem_valid_o(mem_valid_o),
    .ram_stall_if_o(ram_stall_if), .ram_stall_mem_o(ram_stall_mem),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
    .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
    .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
  );

  pipeline_control u_ctrl (
    .clk(clk), .rst(rst),
    .ram_stall_valid_mem_i(ram_stall_mem), .ram_stall_valid_if_i(ram_stall_if),
    .trap_flush_valid_wb_i(trap_flush_i), .trap_stall_valid_wb_i(trap_stall_i),
    .jump_valid_ex_i(ex_jump_i), .alu_mul_div_valid_ex_i(mdu_busy),
    .load_use_valid_id_i(load_use),
    .stall_o(stall_o), .flush_o(flush_o), .cause_o(cause_o)
  );

endmodule

`default_nettype wire

//--- test/tb_pipe_tests.svh
`ifndef TB_PIPE_TESTS_SVH
`define TB_PIPE_TESTS_SVH

// drive slot 10 ns after the rising edge
task automatic next_cycle();
  @(posedge clk);
  #10;
endtask

// sample the codes mid cycle then move on to the next drive slot
task automatic expect_pair(input logic [5:0] exp_stall, input logic [5:0] exp_flush,
                           input pipe_pkg::hazard_cause_e exp_cause);
  @(negedge clk);
  check("stall_o", stall, exp_stall);
  check("flush_o", flush, exp_flush);
  check("cause_o", cause, exp_cause);
  next_cycle();
endtask

task automatic clear_hazards();
  trap_flush  = 1'b0;
  trap_stall  = 1'b0;
  ex_jump     = 1'b0;
  ex_mem_read = 1'b0;
  id_rs1      = '0;
  id_rs2      = '0;
  ex_rd       = '0;
endtask

task automatic reset_behavior();
  for (int n = 0; n < 5; n++) begin
    next_cycle();                   // rst sampled on this edge
    check("stall_o", stall, 6'b000000);
    check("flush_o", flush, 6'b011111);
    check("cause_o", cause, pipe_pkg::RESET);
  end
  rst = 1'b0;
  @(negedge clk);
  check("stall_o", stall, 6'b000000);  // nothing pending after release
  check("flush_o", flush, 6'b000000);
  check("cause_o", cause, pipe_pkg::NONE);
  check("wb_cyc_o", wb_cyc, 1'b0);
  check("wb_stb_o", wb_stb, 1'b0);
  check("mdu_done_o", mdu_done, 1'b0);
  check("if_valid_o", if_valid, 1'b0);
  check("mem_valid_o", mem_valid, 1'b0);
  next_cycle();
endtask

// peel the causes off one at a time from the top
task automatic priority_order();
  id_rs1      = 5'd7;
  ex_rd       = 5'd7;
  ex_mem_read = 1'b1;  // load-use match stays up throughout
  trap_flush  = 1'b1;
  trap_stall  = 1'b1;
  ex_jump     = 1'b1;
  expect_pair(6'b000010, 6'b001110, pipe_pkg::TRAP_FLUSH);
  trap_flush = 1'b0;
  expect_pair(6'b111111, 6'b001110, pipe_pkg::TRAP_STALL);
  trap_stall = 1'b0;
  expect_pair(6'b000010, 6'b000110, pipe_pkg::JUMP);
  ex_jump = 1'b0;
  expect_pair(6'b000011, 6'b000100, pipe_pkg::LOAD_USE);   // load-use last
  clear_hazards();
  expect_pair(6'b000000, 6'b000000, pipe_pkg::NONE);
endtask

task automatic load_use_cases();
  id_rs1      = 5'd3;
  id_rs2      = 5'd9;
  ex_rd       = 5'd3;
  ex_mem_read = 1'b1;
  expect_pair(6'b000011, 6'b000100, pipe_pkg::LOAD_USE);   // rd == rs1
  ex_rd = 5'd9;
  expect_pair(6'b000011, 6'b000100, pipe_pkg::LOAD_USE);   // rd == rs2
  id_rs1 = 5'd0;
  ex_rd  = 5'd0;
  expect_pair(6'b000000, 6'b000000, pipe_pkg::NONE);       // x0 never stalls
  ex_rd       = 5'd9;
  ex_mem_read = 1'b0;
  expect_pair(6'b000000, 6'b000000, pipe_pkg::NONE);       // not a load
  clear_hazards();
endtask

task automatic run_mdu(input pipe_pkg::mdu_op_e op, input logic [31:0] a, input logic [31:0] b,
                       input logic [31:0] exp);
  int waited;
  waited    = 0;
  mdu_op    = op;
  mdu_a     = a;
  mdu_b     = b;
  mdu_start = 1'b1;
  expect_pair(6'b000111, 6'b001000, pipe_pkg::MULDIV);   // busy already in the start cycle
  mdu_start = 1'b0;
  expect_pair(6'b000111, 6'b001000, pipe_pkg::MULDIV);   // first RUN cycle
  @(negedge clk);
  while (mdu_done !== 1'b1 && waited < 40) begin
    check("stall_o", stall, 6'b000111);  // still iterating
    check("flush_o", flush, 6'b001000);
    waited = waited + 1;
    @(negedge clk);
  end
  if (mdu_done !== 1'b1) begin
    errors = errors + 1;
    $display("timeout waiting for mdu_done_o, op %s", op.name());
  end else begin
    check("mdu_result_o", mdu_result, exp);
    check("stall_o", stall, 6'b000000);  // busy low in DONE
  end
  next_cycle();
endtask

task automatic multiply_random();
  logic [31:0] a;
  logic [31:0] b;
  a = $random(seed);
  b = $random(seed);
  run_mdu(pipe_pkg::MDU_MUL, a, b, a * b);  // low word only
endtask

task automatic divide_random();
  logic [31:0] a;
  logic [31:0] b;
  a = $random(seed);
  b = ($random(seed) & 32'h0000ffff) | 32'h1;  // small nonzero divisor
  run_mdu(pipe_pkg::MDU_DIVU, a, b, a / b);
  run_mdu(pipe_pkg::MDU_REMU, a, b, a % b);
endtask

task automatic divide_by_zero();
  logic [31:0] a;
  a = $random(seed);
  run_mdu(pipe_pkg::MDU_DIVU, a, 32'h0, 32'hffffffff);  // all ones per RISC-V
  run_mdu(pipe_pkg::MDU_REMU, a, 32'h0, a);             // remainder is the dividend
endtask

task automatic read_port(input logic use_if, input logic [31:0] addr, output logic [31:0] data);
  int waited;
  waited = 0;
  if (use_if) begin
    if_req  = 1'b1;
    if_addr = addr;
  end else begin
    mem_req  = 1'b1;
    mem_we   = 1'b0;
    mem_addr = addr;
    mem_sel  = 4'hf;
  end
  @(negedge clk);
  while ((use_if ? if_valid : mem_valid) !== 1'b1 && waited < 20) begin
    waited = waited + 1;
    @(negedge clk);
  end
  if ((use_if ? if_valid : mem_valid) !== 1'b1) begin
    errors = errors + 1;
    $display("timeout waiting for a read at address %h", addr);
  end
  data = use_if ? if_rdata : mem_rdata;
  next_cycle();
  if_req  = 1'b0;
  mem_req = 1'b0;
endtask

task automatic memory_arbitration();
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        seen_cyc;
  int          waited;
  wdata     = $random(seed);
  seen_cyc  = 1'b0;
  waited    = 0;
  if_req    = 1'b1;   // both ports in the same cycle
  if_addr   = 32'h40;
  mem_req   = 1'b1;
  mem_we    = 1'b1;
  mem_addr  = 32'h80;
  mem_wdata = wdata;
  mem_sel   = 4'hf;
  @(negedge clk);
  while (mem_valid !== 1'b1 && waited < 20) begin
    check("stall_o", stall, 6'b001111);
    check("flush_o", flush, 6'b010000);
    check("cause_o", cause, pipe_pkg::RAM_MEM);
    if (wb_cyc === 1'b1 && !seen_cyc) begin
      check("wb_adr_o", wb_adr, 32'h80);  // data port goes first
      check("wb_we_o", wb_we, 1'b1);
      check("wb_sel_o", wb_sel, 4'hf);
      check("wb_dat_o", wb_wdata, wdata);
      seen_cyc = 1'b1;
    end
    waited = waited + 1;
    @(negedge clk);
  end
  if (mem_valid !== 1'b1) begin
    errors = errors + 1;
    $display("timeout waiting for the data port write to finish");
  end
  check("wb_cyc_o", seen_cyc, 1'b1);
  next_cycle();
  mem_req  = 1'b0;
  mem_we   = 1'b0;
  waited   = 0;
  seen_cyc = 1'b0;
  @(negedge clk);
  while (if_valid !== 1'b1 && waited < 20) begin
    check("stall_o", stall, 6'b110000);  // fetch still waiting
    check("flush_o", flush, 6'b000000);
    check("cause_o", cause, pipe_pkg::RAM_IF);
    if (wb_cyc === 1'b1 && !seen_cyc) begin
      check("wb_adr_o", wb_adr, 32'h40);
      check("wb_we_o", wb_we, 1'b0);      // fetch is a full word read
      check("wb_sel_o", wb_sel, 4'hf);
      seen_cyc = 1'b1;
    end
    waited = waited + 1;
    @(negedge clk);
  end
  if (if_valid !== 1'b1) begin
    errors = errors + 1;
    $display("timeout waiting for the fetch to finish");
  end else begin
    check("if_rdata_o", if_rdata, fill_word(8'h10));
  end
  check("wb_cyc_o", seen_cyc, 1'b1);
  next_cycle();
  if_req = 1'b0;
  check("mem[0x20]", mem[8'h20], wdata);  // write landed in the model
  read_port(1'b0, 32'h80, rdata);
  check("mem_rdata_o", rdata, wdata);
  read_port(1'b1, 32'h80, rdata);
  check("if_rdata_o", rdata, wdata);
endtask

`endif

//--- test/tb_pipe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "pipe_settings.svh"

module tb_pipe_ctrl;

  localparam int  NUM_TESTS = 7;
  localparam time WATCHDOG  = (NUM_TESTS * 40 + 50) * 100;  // ns, 40 cycles per test plus slack

  logic clk = 1'b0;
  logic rst = 1'b1;  // high from time 0

  // hazard sources
  logic [`PIPE_REGW-1:0] id_rs1 = '0;
  logic [`PIPE_REGW-1:0] id_rs2 = '0;
  logic [`PIPE_REGW-1:0] ex_rd = '0;
  logic ex_mem_read = 1'b0;
  logic ex_jump = 1'b0;
  logic trap_flush = 1'b0;
  logic trap_stall = 1'b0;
  // mul/div
  logic mdu_start = 1'b0;
  pipe_pkg::mdu_op_e mdu_op = pipe_pkg::MDU_MUL;
  logic [`PIPE_XLEN-1:0] mdu_a = '0;
  logic [`PIPE_XLEN-1:0] mdu_b = '0;
  logic mdu_done;
  logic [`PIPE_XLEN-1:0] mdu_result;
  // fetch and data ports
  logic if_req = 1'b0;
  logic [`PIPE_XLEN-1:0] if_addr = '0;
  logic [`PIPE_XLEN-1:0] if_rdata;
  logic if_valid;
  logic mem_req = 1'b0;
  logic mem_we = 1'b0;
  logic [`PIPE_XLEN-1:0] mem_addr = '0;
  logic [`PIPE_XLEN-1:0] mem_wdata = '0;
  logic [3:0] mem_sel = '0;
  logic [`PIPE_XLEN-1:0] mem_rdata;
  logic mem_valid;
  // wishbone
  logic wb_cyc, wb_stb, wb_we;
  logic [`PIPE_XLEN-1:0] wb_adr, wb_wdata;
  logic [3:0] wb_sel;
  logic [`PIPE_XLEN-1:0] wb_rdata = '0;  // driven by the slave model
  logic wb_ack = 1'b0;
  // control outputs
  logic [`PIPE_NSTG-1:0] stall, flush;
  pipe_pkg::hazard_cause_e cause;

  integer seed = 22;
  integer rnd;
  int errors = 0;
  int checks = 0;
  logic [31:0] mem [0:255];  // slave memory, word addressed
  logic [1:0] ack_wait = 2'd0;

  always #50 clk = ~clk;

  pipe_ctrl_top DUT (
    .clk(clk), .rst(rst),
    .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .ex_rd_i(ex_rd), .ex_mem_read_i(ex_mem_read),
    .ex_jump_i(ex_jump), .trap_flush_i(trap_flush), .trap_stall_i(trap_stall),
    .mdu_start_i(mdu_start), .mdu_op_i(mdu_op), .mdu_a_i(mdu_a), .mdu_b_i(mdu_b),
    .mdu_done_o(mdu_done), .mdu_result_o(mdu_result),
    .if_req_i(if_req), .if_addr_i(if_addr), .if_rdata_o(if_rdata), .if_valid_o(if_valid),
    .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
    .mem_wdata_i(mem_wdata), .mem_sel_i(mem_sel),
    .mem_rdata_o(mem_rdata), .mem_valid_o(mem_valid),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_wdata), .wb_sel_o(wb_sel), .wb_dat_i(wb_rdata), .wb_ack_i(wb_ack),
    .stall_o(stall), .flush_o(flush), .cause_o(cause)
  );

  // initial contents, every word differs
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, ~idx, 8'h5a, idx ^ 8'h3c};
  endfunction

  // wishbone classic slave, registered ack after 0..3 wait cycles
  always @(posedge clk) begin
    if (wb_cyc && wb_stb && !wb_ack) begin
      if (ack_wait == 2'd0) begin
        wb_ack   <= 1'b1;
        wb_rdata <= mem[wb_adr[9:2]];
        if (wb_we)
          for (int i = 0; i < 4; i++)
            if (wb_sel[i])
              mem[wb_adr[9:2]][8*i +: 8] <= wb_wdata[8*i +: 8];  // byte lanes
      end else begin
        ack_wait <= ack_wait - 2'd1;
      end
    end else begin
      wb_ack   <= 1'b0;  // drops on the edge that ends the cycle
      rnd      = $random(seed);
      ack_wait <= rnd[1:0];
    end
  end

  // classic rule, never a strobe outside a cycle
  always @(negedge clk) begin
    if (wb_stb === 1'b1 && wb_cyc !== 1'b1) begin
      errors = errors + 1;
      $display("wb_stb_o was high without wb_cyc_o at %0t", $time);
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  `include "tb_pipe_tests.svh"

  initial begin
    #(WATCHDOG);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(i[7:0]);
    reset_behavior();
    priority_order();
    load_use_cases();
    multiply_random();
    divide_random();
    divide_by_zero();
    memory_arbitration();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
+incdir+test
rtl/pipe_pkg.sv
rtl/load_use_detect.sv
rtl/pipeline_control.sv
rtl/mdu_seq.sv
rtl/mem_arbiter.sv
rtl/pipe_ctrl_top.sv
test/tb_pipe_ctrl.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - include_dirs:
      - include
    files:
      - rtl/pipe_pkg.sv
      - rtl/load_use_detect.sv
      - rtl/pipeline_control.sv
      - rtl/mdu_seq.sv
      - rtl/mem_arbiter.sv
      - rtl/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - include
      - test
    files:
      - test/tb_pipe_ctrl.sv
